/* Bender.yml */
package:
  name: rv_id_stage

sources:
  - files:
      - verilog/rv_id_pkg.sv
      - verilog/id_decoder.sv
      - verilog/imm_gen.sv
      - verilog/id_ex_reg.sv
      - verilog/id_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_id_stage.sv

/* flist.f */
+incdir+sim
verilog/rv_id_pkg.sv
verilog/id_decoder.sv
verilog/imm_gen.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
sim/tb_id_stage.sv

/* sim/tb_id_model.svh */
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// integer group of op and op-imm, sub exists only in register form
function automatic alu_op_e integer_alu_op(input logic [2:0] f3, input logic b30,
                                           input logic is_reg);
    case (f3)
        3'd0:    return (is_reg && b30) ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return b30 ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// expected ID/EX word for one instruction, built field by field
function automatic id_ex_t expected_id_ex(input logic [31:0] instr, input logic [31:0] pc);
    id_ex_t      word;
    id_ctrl_t    c;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] imm;
    opc        = instr[6:0];
    f3         = instr[14:12];
    c          = '0;                            // none, rf and alu all encode as zero
    c.op_a_sel = (opc inside {OPC_AUIPC, OPC_BRANCH, OPC_JAL}) ? OPA_PC : OPA_RF;
    c.op_b_sel = (opc == OPC_OP) ? OPB_RF : OPB_IMM;
    c.wb_en    = !(opc inside {OPC_STORE, OPC_BRANCH});
    c.wb_src   = (opc == OPC_LOAD) ? WB_MEM :
                 (opc inside {OPC_LUI, OPC_JALR, OPC_JAL}) ? WB_IMM : WB_ALU;
    c.branch_b = (opc == OPC_BRANCH);
    c.jal      = (opc == OPC_JAL);
    c.jalr     = (opc == OPC_JALR);
    c.alu_op   = ALU_ADD;                       // address and link forms
    case (opc)
        OPC_LOAD, OPC_OP_IMM, OPC_JALR: c.imm_type = IMM_I;
        OPC_STORE:                      c.imm_type = IMM_S;
        OPC_BRANCH:                     c.imm_type = IMM_B;
        OPC_AUIPC, OPC_LUI:             c.imm_type = IMM_U;
        OPC_JAL:                        c.imm_type = IMM_J;
        OPC_OP:                         c.imm_type = IMM_NONE;
        default: begin                          // csr, fence, unknown
            c.alu_op  = ALU_ERROR;
            c.illegal = 1'b1;
        end
    endcase
    case (opc)
        OPC_OP_IMM: c.alu_op = integer_alu_op(f3, instr[30], 1'b0);
        OPC_OP:     c.alu_op = instr[25] ? alu_op_e'(ALU_MUL + f3)
                                         : integer_alu_op(f3, instr[30], 1'b1);
        OPC_LOAD: begin
            if (f3 inside {3'd0, 3'd1, 3'd2}) c.dmem_type = dmem_type_e'(f3 + 3'd1);
            else if (f3 inside {3'd4, 3'd5}) c.dmem_type = dmem_type_e'(f3);  // lbu, lhu
            else c.illegal = 1'b1;
        end
        OPC_STORE: begin
            if (f3 < 3'd3) c.dmem_type = dmem_type_e'(DMEM_SB + f3);
            else c.illegal = 1'b1;
        end
        OPC_BRANCH: begin
            c.alu_op = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
            c.beq    = (f3 == 3'b000);
            c.blt    = f3[2] & ~f3[0];
            if (f3[2:1] == 2'b01) begin         // funct3 2 and 3 have no branch
                c.alu_op  = ALU_ERROR;
                c.illegal = 1'b1;
            end
        end
        default: ;
    endcase
    imm = {32{instr[31]}};                      // sign fill, low bits patched below
    case (c.imm_type)
        IMM_I:   imm[11:0] = instr[31:20];
        IMM_S:   imm[11:0] = {instr[31:25], instr[11:7]};
        IMM_B:   imm[11:0] = {instr[7], instr[30:25], instr[11:8], 1'b0};
        IMM_U:   imm       = {instr[31:12], 12'h000};
        IMM_J:   imm[19:0] = {instr[19:12], instr[20], instr[30:21], 1'b0};
        default: imm       = '0;
    endcase
    word.ctrl = c;
    word.imm  = imm;
    word.pc   = pc;
    return word;
endfunction

`endif

/* sim/tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_id_pkg::*;

    `include "tb_id_model.svh"

    localparam int XLEN        = XLEN_DEF;
    localparam int CLK_PERIOD  = 8;
    localparam int N_DIRECTED  = 11 * 8 * 4;    // opcodes x funct3 x funct7 forms
    localparam int N_SEQ       = 12;
    localparam int N_RANDOM    = 400;
    localparam int TEST_CYCLES = 2 + 2 + N_DIRECTED + N_SEQ + N_RANDOM + 1;

    logic            clk_i = 1'b0;
    logic            rst_n_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] pc_i;
    logic            valid_i, stall_i, flush_i;
    id_ex_t          id_ex_o;
    logic            valid_o;

    integer seed;
    int     error_count = 0;
    id_ex_t model_word;                         // register contents as the tb tracks them
    logic   model_valid;
    id_ex_t exp_word_q[$];
    logic   exp_valid_q[$];

    // nine classes plus fence and system, both illegal here
    logic [6:0] opcodes [11] = '{OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_STORE, OPC_OP,
                                 OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL,
                                 7'b0001111, 7'b1110011};
    logic [6:0] f7_forms [4] = '{7'b0000000, 7'b0100000, 7'b0000001, 7'b1111111};
    // {valid, stall, flush}: load, hold, flush under stall, resume, flush, hold
    logic [2:0] seq_ctrl [N_SEQ] = '{3'b100, 3'b110, 3'b010, 3'b110, 3'b111, 3'b100,
                                     3'b100, 3'b100, 3'b100, 3'b101, 3'b010, 3'b100};

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    id_stage #(.XLEN(XLEN)) id_stage_i (.*);

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    // drives one cycle and queues what the register holds after the next edge
    task automatic drive_cycle(input logic [31:0] w, input logic [31:0] p, input logic v,
                               input logic s, input logic f);
        instr_i = w;
        pc_i    = p;
        valid_i = v;
        stall_i = s;
        flush_i = f;
        if (f) begin
            model_valid = 1'b0;                 // payload stays
        end else if (!s) begin
            model_word  = expected_id_ex(w, p);
            model_valid = v;
        end
        exp_word_q.push_back(model_word);
        exp_valid_q.push_back(model_valid);
        @(posedge clk_i);
        #1;
    endtask

    initial begin : stimulus
        logic [31:0] word;
        logic [31:0] next_pc;
        logic [31:0] ctl;
        seed        = 32'h06ee851c;
        rst_n_i     = 1'b0;
        instr_i     = '0;
        pc_i        = '0;
        {valid_i, stall_i, flush_i} = 3'b000;
        model_word  = '0;                       // reset value of the payload
        model_valid = 1'b0;
        next_pc     = 32'h0000_1000;
        repeat (2) @(posedge clk_i);
        #1;
        check_value("valid_o", 1'b0, valid_o);
        rst_n_i = 1'b1;
        repeat (2) drive_cycle('0, '0, 1'b0, 1'b0, 1'b0);   // valid_o must stay low
        // ==============================
        // directed sweep
        // ==============================
        for (int o = 0; o < 11; o++)
            for (int f = 0; f < 8; f++)
                for (int v = 0; v < 4; v++) begin
                    word        = $random(seed);
                    word[6:0]   = opcodes[o];
                    word[14:12] = f[2:0];
                    word[31:25] = f7_forms[v];      // base, sub/sra, mul group, negative
                    drive_cycle(word, next_pc, 1'b1, 1'b0, 1'b0);
                    next_pc = next_pc + 4;
                end
        for (int i = 0; i < N_SEQ; i++) begin
            word = $random(seed);
            drive_cycle(word, next_pc, seq_ctrl[i][2], seq_ctrl[i][1], seq_ctrl[i][0]);
            next_pc = next_pc + 4;
        end
        // ==============================
        // random words with random stall and flush
        // ==============================
        repeat (N_RANDOM) begin
            word         = $random(seed);
            next_pc      = $random(seed);
            ctl          = $random(seed);
            next_pc[1:0] = 2'b00;
            drive_cycle(word, next_pc, ctl[3:0] != 4'h0, ctl[6:4] == 3'h0, ctl[10:7] == 4'h0);
        end
        @(negedge clk_i);
        #1;
        if (exp_valid_q.size() != 0) begin
            error_count++;
            $display("ERROR: %0d expected results were never compared", exp_valid_q.size());
        end
        $display("errors: %0d", error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin : compare
        id_ex_t exp_word;
        logic   exp_valid;
        @(posedge rst_n_i);
        forever begin
            @(posedge clk_i);
            #(CLK_PERIOD / 2);                  // mid-cycle, outputs settled
            if (exp_valid_q.size() == 0) begin
                error_count++;
                $display("ERROR: at %0t a clock edge had no expected result", $time);
            end else begin
                exp_word  = exp_word_q.pop_front();
                exp_valid = exp_valid_q.pop_front();
                check_value("valid_o", exp_valid, valid_o);
                if (exp_valid) begin
                    check_value("id_ex_o.ctrl", exp_word.ctrl, id_ex_o.ctrl);
                    check_value("id_ex_o.imm", exp_word.imm, id_ex_o.imm);
                    check_value("id_ex_o.pc", exp_word.pc, id_ex_o.pc);
                end
            end
        end
    end

    initial begin : watchdog
        #((TEST_CYCLES + 20) * CLK_PERIOD);
        $display("TIMEOUT: the test did not end within %0d cycles", TEST_CYCLES + 20);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verilog/id_decoder.sv */
module id_decoder (
    input  logic [31:0]         instr_i,
    output rv_id_pkg::id_ctrl_t ctrl_o
);
    import rv_id_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt_bit;                        // bit 30, sub and sra

    assign opcode  = opcode_e'(instr_i[6:0]);
    assign funct3  = instr_i[14:12];
    assign alt_bit = instr_i[30];

    always_comb begin
        // defaults, overridden per opcode
        ctrl_o.alu_op    = ALU_ERROR;
        ctrl_o.op_a_sel  = OPA_RF;
        ctrl_o.op_b_sel  = OPB_IMM;
        ctrl_o.imm_type  = IMM_NONE;
        ctrl_o.beq       = 1'b0;
        ctrl_o.blt       = 1'b0;
        ctrl_o.branch_b  = 1'b0;
        ctrl_o.jal       = 1'b0;
        ctrl_o.jalr      = 1'b0;
        ctrl_o.dmem_type = DMEM_NONE;
        ctrl_o.wb_src    = WB_ALU;
        ctrl_o.wb_en     = 1'b1;
        ctrl_o.illegal   = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                ctrl_o.imm_type = IMM_I;
                ctrl_o.alu_op   = ALU_ADD;          // address calc
                ctrl_o.wb_src   = WB_MEM;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = DMEM_LB;
                    3'b001:  ctrl_o.dmem_type = DMEM_LH;
                    3'b010:  ctrl_o.dmem_type = DMEM_LW;
                    3'b100:  ctrl_o.dmem_type = DMEM_LBU;
                    3'b101:  ctrl_o.dmem_type = DMEM_LHU;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl_o.imm_type = IMM_I;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = ALU_ADD;   // addi
                    3'b001:  ctrl_o.alu_op = ALU_SLL;   // slli
                    3'b010:  ctrl_o.alu_op = ALU_SLT;   // slti
                    3'b011:  ctrl_o.alu_op = ALU_SLTU;  // sltiu
                    3'b100:  ctrl_o.alu_op = ALU_XOR;   // xori
                    3'b101:  ctrl_o.alu_op = alt_bit ? ALU_SRA : ALU_SRL;
                    3'b110:  ctrl_o.alu_op = ALU_OR;    // ori
                    default: ctrl_o.alu_op = ALU_AND;   // andi
                endcase
            end
            OPC_AUIPC: begin
                ctrl_o.imm_type = IMM_U;
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.op_a_sel = OPA_PC;               // pc + imm
            end
            OPC_STORE: begin
                ctrl_o.imm_type = IMM_S;
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.wb_en    = 1'b0;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = DMEM_SB;
                    3'b001:  ctrl_o.dmem_type = DMEM_SH;
                    3'b010:  ctrl_o.dmem_type = DMEM_SW;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            OPC_OP: begin
                ctrl_o.op_b_sel = OPB_RF;               // register-register
                if (instr_i[25]) begin                  // M extension
                    case (funct3)
                        3'b000:  ctrl_o.alu_op = ALU_MUL;
                        3'b001:  ctrl_o.alu_op = ALU_MULH;
                        3'b010:  ctrl_o.alu_op = ALU_MULHSU;
                        3'b011:  ctrl_o.alu_op = ALU_MULHU;
                        3'b100:  ctrl_o.alu_op = ALU_DIV;
                        3'b101:  ctrl_o.alu_op = ALU_DIVU;
                        3'b110:  ctrl_o.alu_op = ALU_REM;
                        default: ctrl_o.alu_op = ALU_REMU;
                    endcase
                end else begin
                    case (funct3)
                        3'b000:  ctrl_o.alu_op = alt_bit ? ALU_SUB : ALU_ADD;
                        3'b001:  ctrl_o.alu_op = ALU_SLL;
                        3'b010:  ctrl_o.alu_op = ALU_SLT;
                        3'b011:  ctrl_o.alu_op = ALU_SLTU;
                        3'b100:  ctrl_o.alu_op = ALU_XOR;
                        3'b101:  ctrl_o.alu_op = alt_bit ? ALU_SRA : ALU_SRL;
                        3'b110:  ctrl_o.alu_op = ALU_OR;
                        default: ctrl_o.alu_op = ALU_AND;
                    endcase
                end
            end
            OPC_LUI: begin
                ctrl_o.imm_type = IMM_U;
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.wb_src   = WB_IMM;               // imm straight to rd
            end
            OPC_BRANCH: begin
                ctrl_o.imm_type = IMM_B;
                ctrl_o.branch_b = 1'b1;
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.wb_en    = 1'b0;
                case (funct3)
                    3'b000: begin                       // beq
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.beq    = 1'b1;
                    end
                    3'b001:  ctrl_o.alu_op = ALU_SUB;   // bne
                    3'b100: begin                       // blt
                        ctrl_o.alu_op = ALU_SLT;
                        ctrl_o.blt    = 1'b1;
                    end
                    3'b101:  ctrl_o.alu_op = ALU_SLT;   // bge
                    3'b110: begin                       // bltu
                        ctrl_o.alu_op = ALU_SLTU;
                        ctrl_o.blt    = 1'b1;
                    end
                    3'b111:  ctrl_o.alu_op = ALU_SLTU;  // bgeu
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_JALR: begin
                ctrl_o.imm_type = IMM_I;
                ctrl_o.jalr     = 1'b1;
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.wb_src   = WB_IMM;
            end
            OPC_JAL: begin
                ctrl_o.imm_type = IMM_J;
                ctrl_o.jal      = 1'b1;
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.wb_src   = WB_IMM;
            end
            default: ctrl_o.illegal = 1'b1;             // csr, fence, unknown
        endcase
    end

endmodule

/* verilog/id_ex_reg.sv */
module id_ex_reg #(
    parameter int XLEN = rv_id_pkg::XLEN_DEF
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  rv_id_pkg::id_ctrl_t ctrl_i,
    input  logic [XLEN-1:0]     imm_i,
    input  logic [XLEN-1:0]     pc_i,
    output rv_id_pkg::id_ex_t   id_ex_o,
    output logic                valid_o
);
    import rv_id_pkg::*;

    id_ex_t next_word;                          // merged decode results

    assign next_word.ctrl = ctrl_i;
    assign next_word.imm  = imm_i;
    assign next_word.pc   = pc_i;

    // ==============================
    // flush > stall > load
    // ==============================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;                    // payload left as is
        end else if (!stall_i) begin
            id_ex_o <= next_word;
            valid_o <= valid_i;
        end
    end

endmodule

/* verilog/id_stage.sv */
module id_stage #(
    parameter int XLEN = rv_id_pkg::XLEN_DEF
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [31:0]       instr_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic              valid_i,
    input  logic              stall_i,
    input  logic              flush_i,
    output rv_id_pkg::id_ex_t id_ex_o,
    output logic              valid_o
);
    import rv_id_pkg::*;

    id_ctrl_t        ctrl;                      // decoder result
    logic [XLEN-1:0] imm;                       // immediate result

    id_decoder id_decoder_i (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    imm_gen #(.XLEN(XLEN)) imm_gen_i (
        .instr_i    (instr_i),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    id_ex_reg #(.XLEN(XLEN)) id_ex_reg_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .ctrl_i  (ctrl),
        .imm_i   (imm),
        .pc_i    (pc_i),
        .id_ex_o (id_ex_o),
        .valid_o (valid_o)
    );

endmodule

/* verilog/imm_gen.sv */
module imm_gen #(
    parameter int XLEN = rv_id_pkg::XLEN_DEF
) (
    input  logic [31:0]          instr_i,
    input  rv_id_pkg::imm_type_e imm_type_i,
    output logic [XLEN-1:0]      imm_o
);
    import rv_id_pkg::*;

    logic        sign;
    logic [31:0] imm_raw;                       // 32-bit form before widening

    assign sign = instr_i[31];

    // ==============================
    // per-format extraction
    // ==============================
    always_comb begin
        case (imm_type_i)
            IMM_I: imm_raw = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_raw = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: begin
                imm_raw = {{19{sign}}, instr_i[31], instr_i[7],
                           instr_i[30:25], instr_i[11:8], 1'b0};   // halfword aligned
            end
            IMM_U: imm_raw = {instr_i[31:12], 12'b0};              // upper 20 bits
            IMM_J: begin
                imm_raw = {{11{sign}}, instr_i[31], instr_i[19:12],
                           instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm_raw = '0;              // no immediate
        endcase
    end

    // sign extension up to XLEN
    assign imm_o = XLEN'($signed(imm_raw));

endmodule

/* verilog/rv_id_pkg.sv */
package rv_id_pkg;

    parameter int XLEN_DEF = 32;                // default data width

    // ==============================
    // opcodes
    // ==============================
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,                // base and M extension
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ==============================
    // control field encodings
    // ==============================
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_MUL    = 5'd10,
        ALU_MULH   = 5'd11,
        ALU_MULHSU = 5'd12,
        ALU_MULHU  = 5'd13,
        ALU_DIV    = 5'd14,
        ALU_DIVU   = 5'd15,
        ALU_REM    = 5'd16,
        ALU_REMU   = 5'd17,
        ALU_ERROR  = 5'd31                      // no valid operation
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [3:0] {
        DMEM_NONE, DMEM_LB, DMEM_LH, DMEM_LW, DMEM_LBU, DMEM_LHU,
        DMEM_SB, DMEM_SH, DMEM_SW
    } dmem_type_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_IMM
    } wb_src_e;

    typedef enum logic {OPA_RF, OPA_PC} op_a_sel_e;
    typedef enum logic {OPB_RF, OPB_IMM} op_b_sel_e;

    // ==============================
    // pipeline structs
    // ==============================
    typedef struct packed {
        alu_op_e    alu_op;
        op_a_sel_e  op_a_sel;                   // rs1 or pc
        op_b_sel_e  op_b_sel;                   // rs2 or imm
        imm_type_e  imm_type;
        logic       beq;
        logic       blt;                        // blt, bltu
        logic       branch_b;                   // any B-type
        logic       jal;
        logic       jalr;
        dmem_type_e dmem_type;
        wb_src_e    wb_src;
        logic       wb_en;
        logic       illegal;                    // trap raised downstream
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t            ctrl;
        logic [XLEN_DEF-1:0] imm;
        logic [XLEN_DEF-1:0] pc;
    } id_ex_t;

endpackage
